//--- Makefile
# Verilator build and run of the ID/EX slice testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_id_ex with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_id_ex -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_id_ex

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+src
+incdir+tests
src/isa_pkg.sv
src/pipe_pkg.sv
src/id_decode.sv
src/stage_reg.sv
src/ex_alu.sv
src/id_ex_core.sv
tests/tb_id_ex.sv

//--- src/ex_alu.sv
`include "mips_defs.svh"

module ex_alu (
    input  logic [`DATA_W-1:0] shamt,
    input  logic [`DATA_W-1:0] immediate,
    input  logic [`DATA_W-1:0] rs_or_pc4,
    input  logic [`DATA_W-1:0] rt,
    input  isa_pkg::alu_op_e   alu_op,
    input  logic               a_use_shamt,
    input  logic               b_use_imm,
    output logic [`DATA_W-1:0] result,
    output logic [`DATA_W-1:0] store_data
);

    logic [`DATA_W-1:0]  op_a;
    logic [`DATA_W-1:0]  op_b;
    logic [`SHAMT_W-1:0] shift_by;
    logic                shift_op;

    // ============================================================
    // operand select
    // ============================================================
    assign op_a     = a_use_shamt ? shamt : rs_or_pc4;
    assign op_b     = b_use_imm ? immediate : rt;
    assign shift_by = op_a[`SHAMT_W-1:0];

    assign shift_op = (alu_op == isa_pkg::ALU_SLL) ||
                      (alu_op == isa_pkg::ALU_SRL) ||
                      (alu_op == isa_pkg::ALU_SRA);

    // sw data goes straight through
    assign store_data = rt;

    // ============================================================
    // alu and shifter
    // ============================================================
    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD: result = op_a + op_b;
            isa_pkg::ALU_SUB: result = op_a - op_b;
            isa_pkg::ALU_AND: result = op_a & op_b;
            isa_pkg::ALU_OR:  result = op_a | op_b;
            isa_pkg::ALU_XOR: result = op_a ^ op_b;
            isa_pkg::ALU_NOR: result = ~(op_a | op_b);
            isa_pkg::ALU_SLT: begin
                result = {{(`DATA_W-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            isa_pkg::ALU_SLL: result = op_b << shift_by;
            isa_pkg::ALU_SRL: result = op_b >> shift_by;
            isa_pkg::ALU_SRA: result = $unsigned($signed(op_b) >>> shift_by);
            // upper half from the immediate, lower half cleared
            isa_pkg::ALU_LUI: result = {op_b[15:0], {(`DATA_W-16){1'b0}}};
            default:          result = '0;
        endcase

        // decode selects shamt for sll/srl/sra only
        shamt_only_for_shift: assert (a_use_shamt !== 1'b1 || shift_op)
            else $error("ex_alu: shamt operand selected for a non-shift op");
    end

endmodule

//--- src/id_decode.sv
`include "mips_defs.svh"

module id_decode (
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] pc4,
    input  logic [`DATA_W-1:0] rs_data,
    input  logic [`DATA_W-1:0] rt_data,
    output logic [`DATA_W-1:0] shamt,
    output logic [`DATA_W-1:0] immediate,
    output logic [`DATA_W-1:0] rs_or_pc4,
    output logic [`DATA_W-1:0] rt_out,
    output isa_pkg::alu_op_e   alu_op,
    output logic [`REG_AW-1:0] write_addr,
    output logic               reg_write,
    output logic               mem_write,
    output logic               mem_to_reg,
    output logic               a_use_shamt,
    output logic               b_use_imm,
    output logic               branch_taken,
    output logic [`DATA_W-1:0] branch_pc
);

    isa_pkg::opcode_e   opcode;
    isa_pkg::funct_e    funct;
    logic [`REG_AW-1:0] rt_addr;
    logic [`REG_AW-1:0] rd_addr;
    logic [`DATA_W-1:0] sext_imm;
    logic [`DATA_W-1:0] zext_imm;
    logic [`DATA_W-1:0] branch_target;
    logic [`DATA_W-1:0] jump_target;
    logic               operands_equal;

    // instruction fields
    assign opcode   = isa_pkg::opcode_e'(instr[31:26]);
    assign funct    = isa_pkg::funct_e'(instr[5:0]);
    assign rt_addr  = instr[20:16];
    assign rd_addr  = instr[15:11];
    assign sext_imm = {{(`DATA_W-16){instr[15]}}, instr[15:0]};
    assign zext_imm = {{(`DATA_W-16){1'b0}}, instr[15:0]};
    assign shamt    = {{(`DATA_W-`SHAMT_W){1'b0}}, instr[10:6]};

    // no jal, so the a operand is always rs
    assign rs_or_pc4 = rs_data;
    assign rt_out    = rt_data;

    // ============================================================
    // branch and jump resolution
    // ============================================================
    assign operands_equal = (rs_data == rt_data);
    assign branch_target  = pc4 + {sext_imm[`DATA_W-3:0], 2'b00};
    assign jump_target    = {pc4[`DATA_W-1:28], instr[25:0], 2'b00};
    assign branch_pc      = (opcode == isa_pkg::OP_J) ? jump_target : branch_target;

    // ============================================================
    // control decode
    // ============================================================
    always_comb begin
        alu_op       = isa_pkg::ALU_ADD;
        immediate    = zext_imm;
        write_addr   = rt_addr;
        reg_write    = 1'b0;
        mem_write    = 1'b0;
        mem_to_reg   = 1'b0;
        a_use_shamt  = 1'b0;
        b_use_imm    = 1'b0;
        branch_taken = 1'b0;

        case (opcode)
            isa_pkg::OP_RTYPE: begin
                write_addr = rd_addr;
                reg_write  = 1'b1;
                case (funct)
                    isa_pkg::FN_ADDU: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::FN_SLL: begin
                        alu_op      = isa_pkg::ALU_SLL;
                        a_use_shamt = 1'b1;
                    end
                    isa_pkg::FN_SRL: begin
                        alu_op      = isa_pkg::ALU_SRL;
                        a_use_shamt = 1'b1;
                    end
                    isa_pkg::FN_SRA: begin
                        alu_op      = isa_pkg::ALU_SRA;
                        a_use_shamt = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                immediate = sext_imm;
                b_use_imm = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::OP_SLTI: begin
                alu_op    = isa_pkg::ALU_SLT;
                immediate = sext_imm;
                b_use_imm = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::OP_ANDI: begin
                alu_op    = isa_pkg::ALU_AND;
                b_use_imm = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::OP_ORI: begin
                alu_op    = isa_pkg::ALU_OR;
                b_use_imm = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::OP_XORI: begin
                alu_op    = isa_pkg::ALU_XOR;
                b_use_imm = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                alu_op    = isa_pkg::ALU_LUI;
                b_use_imm = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::OP_LW: begin
                immediate  = sext_imm;
                b_use_imm  = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            isa_pkg::OP_SW: begin
                immediate = sext_imm;
                b_use_imm = 1'b1;
                mem_write = 1'b1;
            end
            isa_pkg::OP_BEQ: begin
                immediate    = sext_imm;
                branch_taken = operands_equal;
            end
            isa_pkg::OP_BNE: begin
                immediate    = sext_imm;
                branch_taken = !operands_equal;
            end
            isa_pkg::OP_J: branch_taken = 1'b1;
            default: ;
        endcase

        // a redirect squashes this slot, so it must never claim a write
        branch_no_write: assert (!(branch_taken === 1'b1 && reg_write === 1'b1))
            else $error("branch or jump decoded with reg_write set");
    end

endmodule

//--- src/id_ex_core.sv
`include "mips_defs.svh"

module id_ex_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_en,
    input  logic               stall,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] pc4,
    input  logic [`DATA_W-1:0] rs_data,
    input  logic [`DATA_W-1:0] rt_data,
    output logic               ex_mem_write,
    output logic [`DATA_W-1:0] wb_result,
    output logic [`DATA_W-1:0] wb_store_data,
    output logic [`REG_AW-1:0] wb_reg_addr,
    output logic               wb_reg_write,
    output logic               wb_mem_to_reg,
    output logic               branch_taken,
    output logic [`DATA_W-1:0] branch_pc
);

    logic [`DATA_W-1:0] dec_shamt;
    logic [`DATA_W-1:0] dec_immediate;
    logic [`DATA_W-1:0] dec_rs_or_pc4;
    logic [`DATA_W-1:0] dec_rt;
    isa_pkg::alu_op_e   dec_alu_op;
    logic [`REG_AW-1:0] dec_write_addr;
    logic               dec_reg_write;
    logic               dec_mem_write;
    logic               dec_mem_to_reg;
    logic               dec_a_use_shamt;
    logic               dec_b_use_imm;
    logic               id_flush;
    pipe_pkg::id_ex_t   id_ex_d;
    pipe_pkg::id_ex_t   id_ex_q;
    logic [`DATA_W-1:0] ex_result;
    logic [`DATA_W-1:0] ex_store_data;
    pipe_pkg::ex_wb_t   ex_wb_d;
    pipe_pkg::ex_wb_t   ex_wb_q;

    // ============================================================
    // decode
    // ============================================================
    id_decode u_decode (
        .instr        (instr),
        .pc4          (pc4),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .shamt        (dec_shamt),
        .immediate    (dec_immediate),
        .rs_or_pc4    (dec_rs_or_pc4),
        .rt_out       (dec_rt),
        .alu_op       (dec_alu_op),
        .write_addr   (dec_write_addr),
        .reg_write    (dec_reg_write),
        .mem_write    (dec_mem_write),
        .mem_to_reg   (dec_mem_to_reg),
        .a_use_shamt  (dec_a_use_shamt),
        .b_use_imm    (dec_b_use_imm),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    // stalled or redirected slot enters id/ex as a bubble
    assign id_flush = stall || branch_taken;

    assign id_ex_d = '{
        instruction: instr,
        shamt:       dec_shamt,
        immediate:   dec_immediate,
        rs_or_pc4:   dec_rs_or_pc4,
        rt:          dec_rt,
        alu_op:      dec_alu_op,
        write_addr:  dec_write_addr,
        reg_write:   dec_reg_write,
        mem_write:   dec_mem_write,
        mem_to_reg:  dec_mem_to_reg,
        a_use_shamt: dec_a_use_shamt,
        b_use_imm:   dec_b_use_imm
    };

    stage_reg #(.payload_t(pipe_pkg::id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst   (rst),
        .en    (cpu_en),
        .flush (id_flush),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // ============================================================
    // execute
    // ============================================================
    ex_alu u_ex (
        .shamt       (id_ex_q.shamt),
        .immediate   (id_ex_q.immediate),
        .rs_or_pc4   (id_ex_q.rs_or_pc4),
        .rt          (id_ex_q.rt),
        .alu_op      (id_ex_q.alu_op),
        .a_use_shamt (id_ex_q.a_use_shamt),
        .b_use_imm   (id_ex_q.b_use_imm),
        .result      (ex_result),
        .store_data  (ex_store_data)
    );

    assign ex_mem_write = id_ex_q.mem_write;

    assign ex_wb_d = '{
        result:     ex_result,
        store_data: ex_store_data,
        write_addr: id_ex_q.write_addr,
        reg_write:  id_ex_q.reg_write,
        mem_to_reg: id_ex_q.mem_to_reg
    };

    stage_reg #(.payload_t(pipe_pkg::ex_wb_t)) u_ex_wb (
        .clk   (clk),
        .rst   (rst),
        .en    (cpu_en),
        .flush (1'b0),
        .d     (ex_wb_d),
        .q     (ex_wb_q)
    );

    // write-back fields
    assign wb_result     = ex_wb_q.result;
    assign wb_store_data = ex_wb_q.store_data;
    assign wb_reg_addr   = ex_wb_q.write_addr;
    assign wb_reg_write  = ex_wb_q.reg_write;
    assign wb_mem_to_reg = ex_wb_q.mem_to_reg;

endmodule

//--- src/isa_pkg.sv
package isa_pkg;

    // ============================================================
    // primary opcodes, instr[31:26]
    // ============================================================
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // r-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } funct_e;

    // ============================================================
    // alu operations, add must stay 0 so a bubble adds zeros
    // ============================================================
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9,
        ALU_LUI = 4'd10
    } alu_op_e;

endpackage

//--- src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath and instruction word width
`define DATA_W 32

// register file address width
`define REG_AW 5

// shift amount field width
`define SHAMT_W 5

`endif

//--- src/pipe_pkg.sv
`include "mips_defs.svh"

package pipe_pkg;

    // ============================================================
    // id/ex payload
    // ============================================================
    typedef struct packed {
        logic [`DATA_W-1:0] instruction;
        logic [`DATA_W-1:0] shamt;
        logic [`DATA_W-1:0] immediate;
        logic [`DATA_W-1:0] rs_or_pc4;
        logic [`DATA_W-1:0] rt;
        isa_pkg::alu_op_e   alu_op;
        logic [`REG_AW-1:0] write_addr;
        logic               reg_write;
        logic               mem_write;
        logic               mem_to_reg;
        logic               a_use_shamt;
        logic               b_use_imm;
    } id_ex_t;

    // ============================================================
    // ex/wb payload
    // ============================================================
    typedef struct packed {
        logic [`DATA_W-1:0] result;
        logic [`DATA_W-1:0] store_data;
        logic [`REG_AW-1:0] write_addr;
        logic               reg_write;
        logic               mem_to_reg;
    } ex_wb_t;

endpackage

//--- src/stage_reg.sv
// enable-and-squash pipeline register, generic over the payload
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // ============================================================
    // register
    // ============================================================
    // rst is qualified by en, same as flush
    always_ff @(posedge clk) begin
        if (en) begin
            if (rst || flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

    // ============================================================
    // checks
    // ============================================================
    // a squashed slot leaves nothing behind, control or payload
    flush_zeroes_q: assert property (
        @(posedge clk) (en && flush) |=> (q == '0)
    ) else $error("stage_reg: q not zero after flush");

endmodule

//--- tests/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// expected write-back fields of one instruction
typedef struct packed {
    logic [`DATA_W-1:0] result;
    logic [`DATA_W-1:0] store_data;
    logic [`REG_AW-1:0] write_addr;
    logic               reg_write;
    logic               mem_to_reg;
    logic               mem_write;
    logic               skip_data;
    logic               skip_addr;
} stage_exp_t;

function automatic logic [`DATA_W-1:0] sign_ext16(input logic [15:0] v);
    return {{(`DATA_W-16){v[15]}}, v};
endfunction

// ============================================================
// branch and jump resolution
// ============================================================
function automatic logic expect_taken(input logic [`DATA_W-1:0] ins,
                                      input logic [`DATA_W-1:0] rs,
                                      input logic [`DATA_W-1:0] rt);
    case (isa_pkg::opcode_e'(ins[31:26]))
        isa_pkg::OP_BEQ: return rs == rt;
        isa_pkg::OP_BNE: return rs != rt;
        isa_pkg::OP_J:   return 1'b1;
        default:         return 1'b0;
    endcase
endfunction

function automatic logic [`DATA_W-1:0] expect_target(input logic [`DATA_W-1:0] ins,
                                                     input logic [`DATA_W-1:0] pc4);
    if (isa_pkg::opcode_e'(ins[31:26]) == isa_pkg::OP_J) begin
        return {pc4[31:28], ins[25:0], 2'b00};
    end
    return pc4 + (sign_ext16(ins[15:0]) << 2);
endfunction

// ============================================================
// decode and execute of one instruction
// ============================================================
function automatic stage_exp_t expect_stage(input logic [`DATA_W-1:0] ins,
                                            input logic [`DATA_W-1:0] rs,
                                            input logic [`DATA_W-1:0] rt);
    stage_exp_t         e;
    logic [`DATA_W-1:0] simm;
    logic [`DATA_W-1:0] zimm;
    logic [4:0]         sh;
    e            = '0;
    simm         = sign_ext16(ins[15:0]);
    zimm         = {{(`DATA_W-16){1'b0}}, ins[15:0]};
    sh           = ins[10:6];
    e.store_data = rt;
    e.write_addr = ins[20:16];
    e.reg_write  = 1'b1;
    case (isa_pkg::opcode_e'(ins[31:26]))
        isa_pkg::OP_RTYPE: begin
            e.write_addr = ins[15:11];
            case (isa_pkg::funct_e'(ins[5:0]))
                isa_pkg::FN_ADDU: e.result = rs + rt;
                isa_pkg::FN_SUBU: e.result = rs - rt;
                isa_pkg::FN_AND:  e.result = rs & rt;
                isa_pkg::FN_OR:   e.result = rs | rt;
                isa_pkg::FN_XOR:  e.result = rs ^ rt;
                isa_pkg::FN_NOR:  e.result = ~(rs | rt);
                isa_pkg::FN_SLT:  e.result = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                isa_pkg::FN_SLL:  e.result = rt << sh;
                isa_pkg::FN_SRL:  e.result = rt >> sh;
                isa_pkg::FN_SRA:  e.result = $unsigned($signed(rt) >>> sh);
                default: begin
                    e.reg_write = 1'b0;
                    e.skip_data = 1'b1;
                    e.skip_addr = 1'b1;
                end
            endcase
        end
        isa_pkg::OP_ADDIU: e.result = rs + simm;
        isa_pkg::OP_SLTI:  e.result = ($signed(rs) < $signed(simm)) ? 32'd1 : 32'd0;
        isa_pkg::OP_ANDI:  e.result = rs & zimm;
        isa_pkg::OP_ORI:   e.result = rs | zimm;
        isa_pkg::OP_XORI:  e.result = rs ^ zimm;
        isa_pkg::OP_LUI:   e.result = {ins[15:0], 16'h0000};
        isa_pkg::OP_LW: begin
            e.result     = rs + simm;
            e.mem_to_reg = 1'b1;
        end
        isa_pkg::OP_SW: begin
            e.result    = rs + simm;
            e.reg_write = 1'b0;
            e.mem_write = 1'b1;
            e.skip_addr = 1'b1;
        end
        // branches and jumps that survive write nothing
        default: begin
            e.reg_write = 1'b0;
            e.skip_data = 1'b1;
            e.skip_addr = 1'b1;
        end
    endcase
    return e;
endfunction

`endif

//--- tests/tb_id_ex.sv
`include "mips_defs.svh"

module tb_id_ex;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_CYCLES    = 2000;
    localparam int          CLEAR_TIMEOUT = 8;
    localparam int          DRAIN_TIMEOUT = 8;
    localparam logic [31:0] LFSR_SEED     = 32'h5c38_b6d3;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

    `include "ref_model.svh"

    logic               clk = 1'b0;
    logic               rst;
    logic               cpu_en;
    logic               stall;
    logic [`DATA_W-1:0] instr;
    logic [`DATA_W-1:0] pc4;
    logic [`DATA_W-1:0] rs_data;
    logic [`DATA_W-1:0] rt_data;
    logic               ex_mem_write;
    logic [`DATA_W-1:0] wb_result;
    logic [`DATA_W-1:0] wb_store_data;
    logic [`REG_AW-1:0] wb_reg_addr;
    logic               wb_reg_write;
    logic               wb_mem_to_reg;
    logic               branch_taken;
    logic [`DATA_W-1:0] branch_pc;

    // model pipeline from id/ex to ex/wb
    stage_exp_t         pipe_ex;
    stage_exp_t         pipe_wb;
    stage_exp_t         now_exp;
    logic               now_taken;
    logic [31:0]        lfsr_state;
    int                 errors;
    int                 holds;
    int                 stalls;
    int                 taken;

    always #5 clk = ~clk;

    id_ex_core dut0 (
        .clk           (clk),
        .rst           (rst),
        .cpu_en        (cpu_en),
        .stall         (stall),
        .instr         (instr),
        .pc4           (pc4),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .ex_mem_write  (ex_mem_write),
        .wb_result     (wb_result),
        .wb_store_data (wb_store_data),
        .wb_reg_addr   (wb_reg_addr),
        .wb_reg_write  (wb_reg_write),
        .wb_mem_to_reg (wb_mem_to_reg),
        .branch_taken  (branch_taken),
        .branch_pc     (branch_pc)
    );

    // ============================================================
    // random source and instruction encoding
    // ============================================================
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input isa_pkg::funct_e fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        return {isa_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    // j reuses this layout with the target in the low 26 bits
    function automatic logic [31:0] i_word(input isa_pkg::opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ============================================================
    // reporting
    // ============================================================
    task automatic abort_run(input string why);
        $display("Test failures found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run({"mismatch on ", name});
        end
    endtask

    // ============================================================
    // per-cycle model and checks
    // ============================================================
    task automatic check_outputs();
        now_exp   = expect_stage(instr, rs_data, rt_data);
        now_taken = expect_taken(instr, rs_data, rt_data);
        check_value("branch_taken", 32'(now_taken), 32'(branch_taken));
        if (now_taken) begin
            check_value("branch_pc", expect_target(instr, pc4), branch_pc);
        end
        check_value("ex_mem_write", 32'(pipe_ex.mem_write), 32'(ex_mem_write));
        check_value("wb_reg_write", 32'(pipe_wb.reg_write), 32'(wb_reg_write));
        check_value("wb_mem_to_reg", 32'(pipe_wb.mem_to_reg), 32'(wb_mem_to_reg));
        if (!pipe_wb.skip_addr) begin
            check_value("wb_reg_addr", 32'(pipe_wb.write_addr), 32'(wb_reg_addr));
        end
        if (!pipe_wb.skip_data) begin
            check_value("wb_result", pipe_wb.result, wb_result);
            check_value("wb_store_data", pipe_wb.store_data, wb_store_data);
        end
    endtask

    task automatic advance_model();
        if (cpu_en) begin
            pipe_wb = pipe_ex;
            if (rst || stall || now_taken) begin
                pipe_ex = '0;
            end else begin
                pipe_ex = now_exp;
            end
        end
        if (!cpu_en) begin
            holds++;
        end else if (stall) begin
            stalls++;
        end else if (now_taken) begin
            taken++;
        end
    endtask

    task automatic step_cycle();
        check_outputs();
        @(posedge clk);
        advance_model();
    endtask

    task automatic drive_random();
        logic [4:0]         rs_f;
        logic [4:0]         rt_f;
        logic [4:0]         rd_f;
        logic [4:0]         sh_f;
        logic [15:0]        imm;
        logic [`DATA_W-1:0] word;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        int                 sel;
        rs_f = 5'(rand_bits(5));
        rt_f = 5'(rand_bits(5));
        rd_f = 5'(rand_bits(5));
        sh_f = 5'(rand_bits(5));
        imm  = 16'(rand_bits(16));
        sel  = int'(rand_bits(5) % 32'd21);
        case (sel)
            0:  word = r_word(isa_pkg::FN_ADDU, rs_f, rt_f, rd_f, sh_f);
            1:  word = r_word(isa_pkg::FN_SUBU, rs_f, rt_f, rd_f, sh_f);
            2:  word = r_word(isa_pkg::FN_AND, rs_f, rt_f, rd_f, sh_f);
            3:  word = r_word(isa_pkg::FN_OR, rs_f, rt_f, rd_f, sh_f);
            4:  word = r_word(isa_pkg::FN_XOR, rs_f, rt_f, rd_f, sh_f);
            5:  word = r_word(isa_pkg::FN_NOR, rs_f, rt_f, rd_f, sh_f);
            6:  word = r_word(isa_pkg::FN_SLT, rs_f, rt_f, rd_f, sh_f);
            7:  word = r_word(isa_pkg::FN_SLL, rs_f, rt_f, rd_f, sh_f);
            8:  word = r_word(isa_pkg::FN_SRL, rs_f, rt_f, rd_f, sh_f);
            9:  word = r_word(isa_pkg::FN_SRA, rs_f, rt_f, rd_f, sh_f);
            10: word = i_word(isa_pkg::OP_ADDIU, rs_f, rt_f, imm);
            11: word = i_word(isa_pkg::OP_SLTI, rs_f, rt_f, imm);
            12: word = i_word(isa_pkg::OP_ANDI, rs_f, rt_f, imm);
            13: word = i_word(isa_pkg::OP_ORI, rs_f, rt_f, imm);
            14: word = i_word(isa_pkg::OP_XORI, rs_f, rt_f, imm);
            15: word = i_word(isa_pkg::OP_LUI, rs_f, rt_f, imm);
            16: word = i_word(isa_pkg::OP_LW, rs_f, rt_f, imm);
            17: word = i_word(isa_pkg::OP_SW, rs_f, rt_f, imm);
            18: word = i_word(isa_pkg::OP_BEQ, rs_f, rt_f, imm);
            19: word = i_word(isa_pkg::OP_BNE, rs_f, rt_f, imm);
            20: word = i_word(isa_pkg::OP_J, rs_f, rt_f, imm);
            default: word = '0;
        endcase
        a = rand_bits(32);
        instr   <= word;
        pc4     <= rand_bits(30) << 2;
        rs_data <= a;
        // equal operands a quarter of the time so beq gets taken
        if (rand_bits(2) == 32'd0) begin
            b = a;
        end else begin
            b = rand_bits(32);
        end
        rt_data <= b;
        stall   <= (rand_bits(3) == 32'd0);
        cpu_en  <= (rand_bits(5) >= 32'd3);
    endtask

    task automatic drive_drain();
        stall  <= 1'b1;
        cpu_en <= 1'b1;
    endtask

    // ============================================================
    // wait loops
    // ============================================================
    task automatic wait_reset_clear();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wb_reg_write !== 1'b0 || wb_mem_to_reg !== 1'b0 || ex_mem_write !== 1'b0) begin
            if (cycles >= CLEAR_TIMEOUT) begin
                abort_run("write-back controls did not clear after reset");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic drain_pipeline();
        int cycles;
        cycles = 0;
        while (pipe_ex != '0 || pipe_wb != '0) begin
            if (cycles >= DRAIN_TIMEOUT) begin
                abort_run("pipeline did not drain to bubbles with stall held");
            end
            step_cycle();
            drive_drain();
            @(negedge clk);
            cycles++;
        end
        check_outputs();
    endtask

    initial begin
        rst        = 1'b1;
        cpu_en     = 1'b1;
        stall      = 1'b0;
        instr      = '0;
        pc4        = '0;
        rs_data    = '0;
        rt_data    = '0;
        pipe_ex    = '0;
        pipe_wb    = '0;
        lfsr_state = LFSR_SEED;
        errors     = 0;
        holds      = 0;
        stalls     = 0;
        taken      = 0;

        repeat (4) @(posedge clk);
        rst    <= 1'b0;
        cpu_en <= 1'b0;
        wait_reset_clear();

        for (int n = 0; n < NUM_CYCLES; n++) begin
            step_cycle();
            drive_random();
            @(negedge clk);
        end
        drain_pipeline();

        if (holds == 0 || stalls == 0 || taken == 0) begin
            $display("stimulus never produced a freeze, a stall or a taken branch");
            errors++;
        end
        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run("run ended with errors");
        end
    end

endmodule
